// ==== Bender.yml ====
package:
  name: usb_fx3_core

export_include_dirs:
  - include

sources:
  - hw/fx3_pkg.sv
  - hw/fx3_rx_deframer.sv
  - hw/fx3_tx_framer.sv
  - hw/usb_fx3_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/usb_fx3_properties.sv
      - tests/tb_usb_fx3_core.sv

// ==== hw/fx3_pkg.sv ====
// ***************************************************************************
// fx3 bridge package
// bus word, length and size types plus the state encodings of both paths
// ***************************************************************************

`include "fx3_defines.svh"

package fx3_pkg;

  // bus word and byte enables
  typedef logic [`FX3_DATA_W-1:0]     data_t;
  typedef logic [`FX3_KEEP_W-1:0]     keep_t;

  // byte counts and configuration
  typedef logic [`FX3_LEN_W-1:0]      length_t;
  typedef logic [`FX3_BUF_SIZE_W-1:0] buf_size_t;
  typedef logic [`FX3_HDR_SIZE_W-1:0] hdr_size_t;

  // fx3 to stream
  typedef enum logic [1:0] {
    RX_IDLE    = 2'd0,
    RX_HEADER  = 2'd1,
    RX_PAYLOAD = 2'd2,
    RX_DISCARD = 2'd3
  } rx_state_t;

  // stream to fx3
  typedef enum logic [1:0] {
    TX_IDLE    = 2'd0,
    TX_PAYLOAD = 2'd1,
    TX_FOOTER  = 2'd2
  } tx_state_t;

endpackage

// ==== hw/fx3_rx_deframer.sv ====
// ***************************************************************************
// fx3 receive deframer
// checks the frame header (magic word and byte length), skips the rest of
// the header and forwards the payload as an axi-stream master with keep,
// last and an early end-of-packet indication
// ***************************************************************************

`timescale 1ns/1ns

`include "fx3_defines.svh"

module fx3_rx_deframer (
  input  logic              clk,
  input  logic              reset,

  // fx3 side
  input  logic              fx3_rx_valid,
  output logic              fx3_rx_ready,
  input  fx3_pkg::data_t    fx3_rx_data,
  input  logic              fx3_rx_sop,
  output logic              fx3_rx_eop,

  // axi-stream master
  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output fx3_pkg::data_t    m_axis_tdata,
  output fx3_pkg::keep_t    m_axis_tkeep,
  output logic              m_axis_tlast,

  // configuration and status
  input  fx3_pkg::hdr_size_t header_size,
  input  fx3_pkg::buf_size_t buffer_size,
  output fx3_pkg::length_t  rx_length,
  output logic              eot_rx,
  output logic              error
);

  import fx3_pkg::*;

  localparam hdr_size_t hdr_step   = hdr_size_t'(`FX3_BYTES_PER_WORD);
  localparam length_t   word_bytes = length_t'(`FX3_BYTES_PER_WORD);
  localparam length_t   eop_lead   = length_t'(`FX3_EOP_LEAD);

  rx_state_t state;
  rx_state_t state_next;
  logic      error_set;

  // byte offset of the header word being received
  hdr_size_t hdr_ptr;
  // payload bytes not yet forwarded, including the current beat
  length_t   remaining;

  logic      xfer;
  logic      magic_ok;
  logic      len_word;
  logic      len_bad;
  logic      hdr_last;
  logic      last_beat;

  assign fx3_rx_ready = m_axis_tready;
  assign xfer         = fx3_rx_valid & fx3_rx_ready;

  assign magic_ok  = (fx3_rx_data == data_t'(`FX3_MAGIC));
  assign len_word  = (hdr_ptr == hdr_step);
  assign len_bad   = (fx3_rx_data == '0) || (fx3_rx_data > length_t'(buffer_size));
  assign hdr_last  = (hdr_ptr == header_size - hdr_step);
  assign last_beat = (remaining <= word_bytes);

  // *************************************************************************
  // state machine
  // *************************************************************************

  always_comb begin
    state_next = state;
    error_set  = 1'b0;
    case (state)
      RX_IDLE, RX_DISCARD: begin
        if (xfer && fx3_rx_sop) begin
          if (magic_ok) begin
            state_next = RX_HEADER;
          end else begin
            state_next = RX_DISCARD;
            error_set  = 1'b1;
          end
        end
      end
      RX_HEADER: begin
        if (xfer) begin
          if (len_word && len_bad) begin
            state_next = RX_DISCARD;
            error_set  = 1'b1;
          end else if (hdr_last) begin
            state_next = RX_PAYLOAD;
          end
        end
      end
      RX_PAYLOAD: begin
        if (xfer && last_beat) begin
          state_next = RX_IDLE;
        end
      end
      default: state_next = RX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RX_IDLE;
      error <= 1'b0;
    end else begin
      state <= state_next;
      // sticky until reset
      error <= error | error_set;
    end
  end

  // header pointer, length capture and payload countdown
  always_ff @(posedge clk) begin
    if ((state == RX_IDLE || state == RX_DISCARD) && xfer && fx3_rx_sop) begin
      hdr_ptr <= hdr_step;
    end else if (state == RX_HEADER && xfer) begin
      hdr_ptr <= hdr_ptr + hdr_step;
      if (len_word) begin
        rx_length <= fx3_rx_data;
        remaining <= fx3_rx_data;
      end
    end else if (state == RX_PAYLOAD && xfer) begin
      remaining <= remaining - word_bytes;
    end
  end

  // *************************************************************************
  // payload output, straight through from the fx3 side
  // *************************************************************************

  assign m_axis_tvalid = (state == RX_PAYLOAD) & fx3_rx_valid;
  assign m_axis_tdata  = fx3_rx_data;
  assign m_axis_tlast  = m_axis_tvalid & last_beat;
  assign eot_rx        = m_axis_tlast & m_axis_tready;
  assign fx3_rx_eop    = m_axis_tvalid & (remaining <= eop_lead);

  // partial word only on the last beat, low lanes first
  always_comb begin
    m_axis_tkeep = '1;
    if (last_beat) begin
      case (remaining[1:0])
        2'd1:    m_axis_tkeep = 4'b0001;
        2'd2:    m_axis_tkeep = 4'b0011;
        2'd3:    m_axis_tkeep = 4'b0111;
        default: m_axis_tkeep = 4'b1111;
      endcase
    end
  end

endmodule

// ==== hw/fx3_tx_framer.sv ====
// ***************************************************************************
// fx3 transmit framer
// passes axi-stream beats to the fx3 side while counting bytes, cuts the
// frame at the buffer size and appends a footer whose first word holds the
// byte count, zero-length packets give a footer-only frame
// ***************************************************************************

`timescale 1ns/1ns

`include "fx3_defines.svh"

module fx3_tx_framer (
  input  logic               clk,
  input  logic               reset,

  // axi-stream slave
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  input  fx3_pkg::data_t     s_axis_tdata,
  input  fx3_pkg::keep_t     s_axis_tkeep,
  input  logic               s_axis_tlast,

  // fx3 side
  input  logic               fx3_tx_ready,
  output logic               fx3_tx_valid,
  output fx3_pkg::data_t     fx3_tx_data,
  output logic               fx3_tx_eop,

  // configuration and status
  input  logic               zlp,
  input  fx3_pkg::hdr_size_t header_size,
  input  fx3_pkg::buf_size_t buffer_size,
  output fx3_pkg::length_t   tx_length,
  output logic               eot_tx
);

  import fx3_pkg::*;

  localparam hdr_size_t hdr_step   = hdr_size_t'(`FX3_BYTES_PER_WORD);
  localparam length_t   word_bytes = length_t'(`FX3_BYTES_PER_WORD);

  tx_state_t state;
  tx_state_t state_next;

  length_t   byte_count;
  length_t   count_next;
  length_t   beat_bytes;
  // byte offset of the footer word on the bus
  hdr_size_t ftr_ptr;

  logic      beat;
  logic      payload_end;
  logic      ftr_last;

  assign beat     = s_axis_tvalid & s_axis_tready;
  assign ftr_last = (ftr_ptr == header_size - hdr_step);

  // keep is contiguous from lane 0
  always_comb begin
    case (s_axis_tkeep)
      4'b0001: beat_bytes = length_t'(1);
      4'b0011: beat_bytes = length_t'(2);
      4'b0111: beat_bytes = length_t'(3);
      default: beat_bytes = word_bytes;
    endcase
  end

  assign count_next  = byte_count + beat_bytes;
  assign payload_end = s_axis_tlast || ((count_next + word_bytes) >= length_t'(buffer_size));

  // *************************************************************************
  // state machine
  // *************************************************************************

  always_comb begin
    state_next = state;
    case (state)
      TX_IDLE: begin
        if (fx3_tx_ready && (zlp || s_axis_tvalid)) begin
          state_next = zlp ? TX_FOOTER : TX_PAYLOAD;
        end
      end
      TX_PAYLOAD: begin
        if (beat && payload_end) begin
          state_next = TX_FOOTER;
        end
      end
      TX_FOOTER: begin
        if (fx3_tx_ready && ftr_last) begin
          state_next = TX_IDLE;
        end
      end
      default: state_next = TX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= TX_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      TX_IDLE: begin
        byte_count <= '0;
        ftr_ptr    <= '0;
      end
      TX_PAYLOAD: begin
        if (beat) begin
          byte_count <= count_next;
        end
      end
      TX_FOOTER: begin
        if (fx3_tx_ready) begin
          ftr_ptr <= ftr_ptr + hdr_step;
          if (ftr_last) begin
            tx_length <= byte_count;
          end
        end
      end
      default: ftr_ptr <= '0;
    endcase
  end

  // *************************************************************************
  // fx3 output
  // *************************************************************************

  always_comb begin
    s_axis_tready = 1'b0;
    fx3_tx_valid  = 1'b0;
    fx3_tx_data   = s_axis_tdata;
    fx3_tx_eop    = 1'b0;
    case (state)
      TX_PAYLOAD: begin
        s_axis_tready = fx3_tx_ready;
        fx3_tx_valid  = s_axis_tvalid & fx3_tx_ready;
      end
      TX_FOOTER: begin
        fx3_tx_valid = 1'b1;
        fx3_tx_data  = (ftr_ptr == '0) ? byte_count : '0;
        fx3_tx_eop   = ftr_last;
      end
      default: ;
    endcase
  end

  assign eot_tx = fx3_tx_eop & fx3_tx_ready;

endmodule

// ==== hw/usb_fx3_core.sv ====
// ***************************************************************************
// usb fx3 bridge top level
// fx3-to-stream and stream-to-fx3 directions side by side, sharing the
// header and buffer size configuration
// ***************************************************************************

`timescale 1ns/1ns

module usb_fx3_core (
  input  logic               clk,
  input  logic               reset,

  // configuration
  input  fx3_pkg::hdr_size_t header_size,
  input  fx3_pkg::buf_size_t buffer_size,
  input  logic               zlp,

  // fx3 receive side
  input  logic               fx3_rx_valid,
  output logic               fx3_rx_ready,
  input  fx3_pkg::data_t     fx3_rx_data,
  input  logic               fx3_rx_sop,
  output logic               fx3_rx_eop,

  // axi-stream master
  output logic               m_axis_tvalid,
  input  logic               m_axis_tready,
  output fx3_pkg::data_t     m_axis_tdata,
  output fx3_pkg::keep_t     m_axis_tkeep,
  output logic               m_axis_tlast,

  // axi-stream slave
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  input  fx3_pkg::data_t     s_axis_tdata,
  input  fx3_pkg::keep_t     s_axis_tkeep,
  input  logic               s_axis_tlast,

  // fx3 transmit side
  input  logic               fx3_tx_ready,
  output logic               fx3_tx_valid,
  output fx3_pkg::data_t     fx3_tx_data,
  output logic               fx3_tx_eop,

  // status
  output fx3_pkg::length_t   rx_length,
  output fx3_pkg::length_t   tx_length,
  output logic               eot_rx,
  output logic               eot_tx,
  output logic               error
);

  fx3_rx_deframer u_rx (
    .clk           (clk),
    .reset         (reset),
    .fx3_rx_valid  (fx3_rx_valid),
    .fx3_rx_ready  (fx3_rx_ready),
    .fx3_rx_data   (fx3_rx_data),
    .fx3_rx_sop    (fx3_rx_sop),
    .fx3_rx_eop    (fx3_rx_eop),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tlast  (m_axis_tlast),
    .header_size   (header_size),
    .buffer_size   (buffer_size),
    .rx_length     (rx_length),
    .eot_rx        (eot_rx),
    .error         (error)
  );

  fx3_tx_framer u_tx (
    .clk           (clk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tlast  (s_axis_tlast),
    .fx3_tx_ready  (fx3_tx_ready),
    .fx3_tx_valid  (fx3_tx_valid),
    .fx3_tx_data   (fx3_tx_data),
    .fx3_tx_eop    (fx3_tx_eop),
    .zlp           (zlp),
    .header_size   (header_size),
    .buffer_size   (buffer_size),
    .tx_length     (tx_length),
    .eot_tx        (eot_tx)
  );

endmodule

// ==== include/fx3_defines.svh ====
// ***************************************************************************
// fx3 bridge shared constants
// word format, field widths, header magic and end-of-packet lead
// ***************************************************************************

`ifndef FX3_DEFINES_SVH
`define FX3_DEFINES_SVH

// bus word
`define FX3_DATA_W          32
`define FX3_KEEP_W          4
`define FX3_BYTES_PER_WORD  4

// length and configuration fields
`define FX3_LEN_W           32
`define FX3_BUF_SIZE_W      16
`define FX3_HDR_SIZE_W      8

// first header word of every frame from the fx3 side
`define FX3_MAGIC           32'h0ff00ff0

// remaining bytes at or below which fx3_rx_eop is raised
`define FX3_EOP_LEAD        12

`endif

// ==== project.f ====
+incdir+include
hw/fx3_pkg.sv
hw/fx3_rx_deframer.sv
hw/fx3_tx_framer.sv
hw/usb_fx3_core.sv
tests/tb_clock_gen.sv
tests/usb_fx3_properties.sv
tests/tb_usb_fx3_core.sv

// ==== tests/tb_clock_gen.sv ====
// ***************************************************************************
// testbench clock and reset
// 20 ns clock, reset held for 10 cycles at start and on every request
// ***************************************************************************

`timescale 1ns/1ns

module tb_clock_gen (
  input  logic reset_req,
  output logic clk,
  output logic reset
);

  // reset cycles still to go
  int unsigned hold = 10;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset_req) begin
      hold <= 10;
    end else if (hold != 0) begin
      hold <= hold - 1;
    end
  end

  assign reset = (hold != 0);

endmodule

// ==== tests/tb_usb_fx3_core.sv ====
// ***************************************************************************
// usb fx3 bridge testbench
// table of frames for both directions with optional random back-pressure,
// checking payload, keep, last, end-of-packet, footer, lengths and error
// ***************************************************************************

`timescale 1ns/1ns

`include "fx3_defines.svh"

module tb_usb_fx3_core;

  import fx3_pkg::*;

  localparam int unsigned timeout_cycles = 2000;
  localparam time         drive_dly      = 2;

  typedef struct {
    bit          is_tx;
    int unsigned hdr_bytes;
    int unsigned buf_bytes;
    int unsigned len;
    data_t       magic;
    bit          zlp_req;
    bit          bp;
    bit          exp_err;
    // rx: m_axis beats, tx: byte count in the footer
    int unsigned exp_count;
  } row_t;

  logic      clk;
  logic      reset;
  logic      reset_req;
  hdr_size_t header_size;
  buf_size_t buffer_size;
  logic      zlp;
  logic      fx3_rx_valid;
  logic      fx3_rx_ready;
  data_t     fx3_rx_data;
  logic      fx3_rx_sop;
  logic      fx3_rx_eop;
  logic      m_axis_tvalid;
  logic      m_axis_tready;
  data_t     m_axis_tdata;
  keep_t     m_axis_tkeep;
  logic      m_axis_tlast;
  logic      s_axis_tvalid;
  logic      s_axis_tready;
  data_t     s_axis_tdata;
  keep_t     s_axis_tkeep;
  logic      s_axis_tlast;
  logic      fx3_tx_ready;
  logic      fx3_tx_valid;
  data_t     fx3_tx_data;
  logic      fx3_tx_eop;
  length_t   rx_length;
  length_t   tx_length;
  logic      eot_rx;
  logic      eot_tx;
  logic      error;

  row_t        rows [$];
  int unsigned seed_init;

  tb_clock_gen clock_gen (.reset_req(reset_req), .clk(clk), .reset(reset));

  usb_fx3_core DUT (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  always @(negedge clk) begin
    if (DUT.u_props.fail_count != 0) begin
      abort_run("concurrent assertion failure on the core ports");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  // low lanes set for a partial word
  function automatic keep_t keep_for_bytes(input int unsigned n);
    if (n >= `FX3_BYTES_PER_WORD) begin
      return 4'hf;
    end
    return keep_t'((1 << n) - 1);
  endfunction

  function automatic data_t word_for(input int r, input int unsigned k);
    return {8'(r), 8'ha5, 16'(k)};
  endfunction

  task automatic drive_idle();
    fx3_rx_valid  = 1'b0;
    fx3_rx_data   = '0;
    fx3_rx_sop    = 1'b0;
    m_axis_tready = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tlast  = 1'b0;
    fx3_tx_ready  = 1'b1;
    zlp           = 1'b0;
  endtask

  task automatic apply_reset(input int r);
    int unsigned cycles;
    @(posedge clk);
    #drive_dly;
    drive_idle();
    header_size = hdr_size_t'(rows[r].hdr_bytes);
    buffer_size = buf_size_t'(rows[r].buf_bytes);
    reset_req   = 1'b1;
    @(posedge clk);
    #drive_dly;
    reset_req = 1'b0;
    cycles    = 0;
    @(negedge clk);
    while (reset) begin
      cycles++;
      assert (cycles < 40) else abort_run("timeout waiting for reset to be released");
      @(negedge clk);
    end
    check_value("error", error, 1'b0);
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_value("fx3_tx_valid", fx3_tx_valid, 1'b0);
  endtask

  // ***************************************************************************
  // receive direction
  // ***************************************************************************

  task automatic run_rx(input int r);
    data_t       words [$];
    int unsigned nhdr;
    int unsigned sent;
    int unsigned beats;
    int unsigned rem;
    int unsigned cycles;
    int unsigned i;
    nhdr = rows[r].hdr_bytes / 4;
    words.push_back(rows[r].magic);
    words.push_back(data_t'(rows[r].len));
    for (i = 2; i < nhdr; i++) begin
      words.push_back('0);
    end
    for (i = 0; i < (rows[r].len + 3) / 4; i++) begin
      words.push_back(word_for(r, i));
    end
    sent   = 0;
    beats  = 0;
    cycles = 0;
    while (sent < words.size()) begin
      @(posedge clk);
      #drive_dly;
      fx3_rx_valid  = 1'b1;
      fx3_rx_data   = words[sent];
      fx3_rx_sop    = (sent == 0);
      m_axis_tready = rows[r].bp ? 1'($urandom % 2) : 1'b1;
      @(negedge clk);
      check_value("fx3_rx_ready", fx3_rx_ready, m_axis_tready);
      if (m_axis_tvalid) begin
        assert (beats < rows[r].exp_count) else abort_run("m_axis beat where none was expected");
        rem = rows[r].len - 4 * beats;
        check_value("m_axis_tdata", m_axis_tdata, words[nhdr + beats]);
        check_value("m_axis_tkeep", m_axis_tkeep, keep_for_bytes(rem));
        check_value("m_axis_tlast", m_axis_tlast, rem <= 4);
        check_value("fx3_rx_eop", fx3_rx_eop, rem <= `FX3_EOP_LEAD);
        check_value("eot_rx", eot_rx, (rem <= 4) && m_axis_tready);
        if (m_axis_tready) begin
          beats++;
        end
      end else begin
        check_value("fx3_rx_eop", fx3_rx_eop, 1'b0);
        check_value("eot_rx", eot_rx, 1'b0);
      end
      if (fx3_rx_ready) begin
        sent++;
      end
      cycles++;
      assert (cycles < timeout_cycles) else abort_run("timeout sending the receive frame");
    end
    @(posedge clk);
    #drive_dly;
    drive_idle();
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    end
    check_value("rx beat count", beats, rows[r].exp_count);
    // a frame error must still be flagged here
    check_value("error", error, rows[r].exp_err);
    if (!rows[r].exp_err) begin
      check_value("rx_length", rx_length, rows[r].len);
    end
  endtask

  // ***************************************************************************
  // transmit direction
  // ***************************************************************************

  task automatic run_tx(input int r);
    int unsigned nbeats;
    int unsigned npay;
    int unsigned nftr;
    int unsigned accepted;
    int unsigned got;
    int unsigned cycles;
    bit          started;
    bit          done;
    data_t       exp_word;
    bit          exp_eop;
    nbeats   = (rows[r].len + 3) / 4;
    npay     = (rows[r].exp_count + 3) / 4;
    nftr     = rows[r].hdr_bytes / 4;
    accepted = 0;
    got      = 0;
    cycles   = 0;
    started  = 1'b0;
    done     = 1'b0;
    while (!done) begin
      @(posedge clk);
      #drive_dly;
      fx3_tx_ready  = rows[r].bp ? 1'($urandom % 2) : 1'b1;
      zlp           = rows[r].zlp_req && !started;
      s_axis_tvalid = (accepted < nbeats);
      s_axis_tdata  = word_for(r, accepted);
      s_axis_tkeep  = keep_for_bytes(rows[r].len - 4 * accepted);
      s_axis_tlast  = (accepted + 1 == nbeats);
      @(negedge clk);
      started = started | fx3_tx_valid;
      if (s_axis_tvalid && s_axis_tready) begin
        accepted++;
      end
      if (fx3_tx_valid && fx3_tx_ready) begin
        assert (got < npay + nftr) else abort_run("extra word on the fx3 transmit side");
        // payload words, then the count word, then zeros
        if (got < npay) begin
          exp_word = word_for(r, got);
        end else if (got == npay) begin
          exp_word = data_t'(rows[r].exp_count);
        end else begin
          exp_word = '0;
        end
        exp_eop = (got == npay + nftr - 1);
        check_value("fx3_tx_data", fx3_tx_data, exp_word);
        check_value("fx3_tx_eop", fx3_tx_eop, exp_eop);
        check_value("eot_tx", eot_tx, exp_eop);
        check_value("s_axis_tready", s_axis_tready, got < npay);
        got++;
        done = fx3_tx_eop;
      end
      cycles++;
      assert (cycles < timeout_cycles) else abort_run("timeout waiting for the transmit footer");
    end
    @(posedge clk);
    #drive_dly;
    drive_idle();
    @(negedge clk);
    check_value("tx_length", tx_length, rows[r].exp_count);
    check_value("tx beats accepted", accepted, npay);
  endtask

  initial begin
    int r;
    reset_req   = 1'b0;
    header_size = '0;
    buffer_size = '0;
    drive_idle();
    seed_init = $urandom(5001);

    // is_tx  hdr  buf  len  magic  zlp  bp  err  count
    rows.push_back('{1'b0,  8, 64,  4, `FX3_MAGIC, 1'b0, 1'b0, 1'b0, 1});
    rows.push_back('{1'b0,  8, 64,  9, `FX3_MAGIC, 1'b0, 1'b0, 1'b0, 3});
    rows.push_back('{1'b0, 16, 64, 10, `FX3_MAGIC, 1'b0, 1'b0, 1'b0, 3});
    rows.push_back('{1'b0, 16, 64, 11, `FX3_MAGIC, 1'b0, 1'b0, 1'b0, 3});
    rows.push_back('{1'b0,  8, 64, 16, `FX3_MAGIC, 1'b0, 1'b0, 1'b0, 4});
    rows.push_back('{1'b0,  8, 64, 10, `FX3_MAGIC, 1'b0, 1'b1, 1'b0, 3});
    rows.push_back('{1'b0, 16, 64, 11, `FX3_MAGIC, 1'b0, 1'b1, 1'b0, 3});
    rows.push_back('{1'b0, 16, 64, 30, `FX3_MAGIC, 1'b0, 1'b1, 1'b0, 8});
    rows.push_back('{1'b0,  8, 64, 16, 32'h0ff00ff1, 1'b0, 1'b0, 1'b1, 0});
    rows.push_back('{1'b0,  8, 64,  0, `FX3_MAGIC, 1'b0, 1'b0, 1'b1, 0});
    rows.push_back('{1'b0, 16, 32, 40, `FX3_MAGIC, 1'b0, 1'b1, 1'b1, 0});
    rows.push_back('{1'b1,  8, 64, 16, `FX3_MAGIC, 1'b0, 1'b0, 1'b0, 16});
    rows.push_back('{1'b1, 16, 64, 23, `FX3_MAGIC, 1'b0, 1'b1, 1'b0, 23});
    rows.push_back('{1'b1,  8, 32, 48, `FX3_MAGIC, 1'b0, 1'b1, 1'b0, 28});
    rows.push_back('{1'b1, 16, 40, 60, `FX3_MAGIC, 1'b0, 1'b0, 1'b0, 36});
    rows.push_back('{1'b1,  8, 64,  0, `FX3_MAGIC, 1'b1, 1'b1, 1'b0, 0});

    for (r = 0; r < rows.size(); r++) begin
      apply_reset(r);
      if (rows[r].is_tx) begin
        run_tx(r);
      end else begin
        run_rx(r);
      end
    end

    if (DUT.u_props.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run("concurrent assertion failures on the core ports");
    end
  end

endmodule

// ==== tests/usb_fx3_properties.sv ====
// ***************************************************************************
// usb fx3 bridge port properties
// handshake rules on both directions and the sticky error flag
// ***************************************************************************

`timescale 1ns/1ns

module usb_fx3_properties (
  input logic clk,
  input logic reset,
  input logic m_axis_tvalid,
  input logic m_axis_tlast,
  input logic s_axis_tvalid,
  input logic s_axis_tready,
  input logic fx3_tx_valid,
  input logic fx3_tx_eop,
  input logic error
);

  int unsigned fail_count = 0;

  last_has_valid: assert property (@(posedge clk) disable iff (reset)
    m_axis_tlast |-> m_axis_tvalid)
    else begin
      $error("m_axis_tlast high without m_axis_tvalid");
      fail_count++;
    end

  eop_has_valid: assert property (@(posedge clk) disable iff (reset)
    fx3_tx_eop |-> fx3_tx_valid)
    else begin
      $error("fx3_tx_eop high without fx3_tx_valid");
      fail_count++;
    end

  // fx3 word with no stream beat behind it is a footer word
  footer_blocks_stream: assert property (@(posedge clk) disable iff (reset)
    (fx3_tx_valid && !s_axis_tvalid) |-> !s_axis_tready)
    else begin
      $error("s_axis_tready high during the footer");
      fail_count++;
    end

  error_sticky: assert property (@(posedge clk)
    $fell(error) |-> $past(reset))
    else begin
      $error("error cleared without reset");
      fail_count++;
    end

endmodule

bind usb_fx3_core usb_fx3_properties u_props (
  .clk           (clk),
  .reset         (reset),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tlast  (m_axis_tlast),
  .s_axis_tvalid (s_axis_tvalid),
  .s_axis_tready (s_axis_tready),
  .fx3_tx_valid  (fx3_tx_valid),
  .fx3_tx_eop    (fx3_tx_eop),
  .error         (error)
);
